/* logic/lsu_pkg.sv */
// LSU shared definitions for bus widths, data types and transfer sizes
package lsu_pkg;

   // ===================================================================
   // Widths
   // ===================================================================

   // Bus word width
   localparam int lsu_data_w = 32;

   // ===================================================================
   // Types
   // ===================================================================

   // Addresses, write data, read data and load results
   typedef logic [lsu_data_w-1:0] data_t;

   // Byte offset inside one bus word
   typedef logic [1:0] lane_off_t;

   // Access size, coded as the AHB transfer size so it maps onto hsize
   typedef enum logic [2:0] {
      size_byte = 3'd0,
      size_half = 3'd1,
      size_word = 3'd2
   } mem_size_e;

endpackage

/* logic/lsu_dphase_if.sv */
// Data-phase context captured when the address phase is accepted
`timescale 1ns/1ps

interface lsu_dphase_if #(
   parameter int reg_addr_w = 5
);
   import lsu_pkg::*;

   // A transfer is in its data phase
   logic                  dp_valid;
   logic                  dp_load;

   // Load destination register
   logic [reg_addr_w-1:0] dp_rd;

   // Controls for read data extraction
   mem_size_e             dp_size;
   logic                  dp_unsigned;
   lane_off_t             dp_offset;

   modport addr_side (
      output dp_valid, dp_load, dp_rd, dp_size, dp_unsigned, dp_offset
   );

   modport load_side (
      input dp_size, dp_unsigned, dp_offset
   );

   modport wb_side (
      input dp_valid, dp_load, dp_rd
   );

endinterface

/* logic/lsu_addr_phase.sv */
// LSU address phase: bus request, store lane placement and data-phase capture
`timescale 1ns/1ps

module lsu_addr_phase #(
   parameter int reg_addr_w = 5
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // Request from execute
   input  logic                  req_valid,
   input  logic                  req_store,
   input  lsu_pkg::mem_size_e    req_size,
   input  logic                  req_unsigned,
   input  lsu_pkg::data_t        req_addr,
   input  lsu_pkg::data_t        req_wdata,
   input  logic [reg_addr_w-1:0] req_rd,
   // Bus ready level
   input  logic                  hready,
   // Forwarding and stall from writeback
   input  logic                  fwd_hit,
   input  lsu_pkg::data_t        fwd_data,
   input  logic                  interlock,
   // AHB-Lite address phase and write data
   output lsu_pkg::data_t        haddr,
   output logic                  htrans,
   output logic                  hwrite,
   output logic [2:0]            hsize,
   output lsu_pkg::data_t        hwdata,
   // Captured context for the data phase
   lsu_dphase_if.addr_side       dp
);
   import lsu_pkg::*;

   data_t     store_src;
   data_t     store_lanes;
   lane_off_t offset;
   logic      accept;

   // ===================================================================
   // Address phase
   // ===================================================================

   // Request goes out unless a pending load blocks it
   assign htrans = req_valid & ~interlock;
   assign haddr  = req_addr;
   assign hwrite = req_store;
   assign hsize  = req_size;

   assign accept = htrans & hready;
   assign offset = req_addr[1:0];

   // ===================================================================
   // Store data lanes
   // ===================================================================

   // Freshly loaded value replaces the stale operand
   assign store_src = fwd_hit ? fwd_data : req_wdata;

   always_comb begin
      store_lanes = '0;
      case (req_size)
         size_byte: begin
            case (offset)
               2'd0: store_lanes[7:0]   = store_src[7:0];
               2'd1: store_lanes[15:8]  = store_src[7:0];
               2'd2: store_lanes[23:16] = store_src[7:0];
               default: store_lanes[31:24] = store_src[7:0];
            endcase
         end
         size_half: begin
            // Only bit 1 of the offset picks the halfword
            if (offset[1]) begin
               store_lanes[31:16] = store_src[15:0];
            end else begin
               store_lanes[15:0] = store_src[15:0];
            end
         end
         default: begin
            store_lanes = store_src;
         end
      endcase
   end

   // ===================================================================
   // Data-phase registers
   // ===================================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp.dp_valid    <= 1'b0;
         dp.dp_load     <= 1'b0;
         dp.dp_rd       <= '0;
         dp.dp_size     <= size_byte;
         dp.dp_unsigned <= 1'b0;
         dp.dp_offset   <= '0;
         hwdata         <= '0;
      end else if (accept) begin
         dp.dp_valid    <= 1'b1;
         dp.dp_load     <= ~req_store;
         dp.dp_rd       <= req_rd;
         dp.dp_size     <= req_size;
         dp.dp_unsigned <= req_unsigned;
         dp.dp_offset   <= offset;
         hwdata         <= store_lanes;
      end else if (hready) begin
         // Data phase over and nothing new accepted
         dp.dp_valid <= 1'b0;
      end
   end

endmodule

/* logic/lsu_load_align.sv */
// LSU load data extraction with sign or zero extension
`timescale 1ns/1ps

module lsu_load_align (
   input  lsu_pkg::data_t   hrdata,
   lsu_dphase_if.load_side  dp,
   output lsu_pkg::data_t   load_data
);
   import lsu_pkg::*;

   logic [7:0]  byte_val;
   logic [15:0] half_val;
   logic        ext_bit;

   // ===================================================================
   // Lane selection
   // ===================================================================

   always_comb begin
      case (dp.dp_offset)
         2'd0: byte_val = hrdata[7:0];
         2'd1: byte_val = hrdata[15:8];
         2'd2: byte_val = hrdata[23:16];
         default: byte_val = hrdata[31:24];
      endcase
   end

   // Halfword lane follows offset bit 1
   assign half_val = dp.dp_offset[1] ? hrdata[31:16] : hrdata[15:0];

   // ===================================================================
   // Extension
   // ===================================================================

   always_comb begin
      ext_bit   = 1'b0;
      load_data = hrdata;
      case (dp.dp_size)
         size_byte: begin
            ext_bit   = ~dp.dp_unsigned & byte_val[7];
            load_data = {{24{ext_bit}}, byte_val};
         end
         size_half: begin
            ext_bit   = ~dp.dp_unsigned & half_val[15];
            load_data = {{16{ext_bit}}, half_val};
         end
         default: begin
            // Full word, nothing to extend
            load_data = hrdata;
         end
      endcase
   end

endmodule

/* logic/lsu_writeback.sv */
// LSU second-port writeback, load-use interlock and load-to-store forwarding
`timescale 1ns/1ps

module lsu_writeback #(
   parameter int reg_addr_w = 5
) (
   input  logic                  hready,
   // Current request from execute
   input  logic                  req_valid,
   input  logic                  req_store,
   input  logic [reg_addr_w-1:0] req_rs1,
   input  logic [reg_addr_w-1:0] req_rs2,
   // Extracted read data
   input  lsu_pkg::data_t        load_data,
   lsu_dphase_if.wb_side         dp,
   // Register file second write port
   output logic                  wb_valid,
   output logic [reg_addr_w-1:0] wb_rd,
   output lsu_pkg::data_t        wb_data,
   // Back to the address phase
   output logic                  fwd_hit,
   output lsu_pkg::data_t        fwd_data,
   output logic                  interlock
);

   logic load_pending;
   logic rs1_hit;
   logic rs2_hit;

   // ===================================================================
   // Writeback
   // ===================================================================

   assign load_pending = dp.dp_valid & dp.dp_load;

   // Result is there in the last data-phase cycle
   assign wb_valid = load_pending & hready;
   assign wb_rd    = dp.dp_rd;
   assign wb_data  = load_data;

   // ===================================================================
   // Hazards
   // ===================================================================

   assign rs1_hit = req_valid & load_pending & (req_rs1 == dp.dp_rd);
   assign rs2_hit = req_valid & load_pending & (req_rs2 == dp.dp_rd);

   // Store data can take the load result as it arrives
   assign fwd_hit  = rs2_hit & req_store & hready;
   assign fwd_data = load_data;

   // Address operand or unforwarded rs2 must wait for the register file
   assign interlock = rs1_hit | (rs2_hit & ~fwd_hit);

endmodule

/* logic/lsu_top.sv */
// LSU top level with one AHB-Lite-style data master port
`timescale 1ns/1ps

module lsu_top #(
   parameter int reg_addr_w = 5
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // Request from execute
   input  logic                  req_valid,
   input  logic                  req_store,
   input  lsu_pkg::mem_size_e    req_size,
   input  logic                  req_unsigned,
   input  lsu_pkg::data_t        req_addr,
   input  lsu_pkg::data_t        req_wdata,
   input  logic [reg_addr_w-1:0] req_rd,
   input  logic [reg_addr_w-1:0] req_rs1,
   input  logic [reg_addr_w-1:0] req_rs2,
   // AHB-Lite master
   input  lsu_pkg::data_t        hrdata,
   input  logic                  hready,
   output lsu_pkg::data_t        haddr,
   output logic                  htrans,
   output logic                  hwrite,
   output logic [2:0]            hsize,
   output lsu_pkg::data_t        hwdata,
   // Second register file write port
   output logic                  wb_valid,
   output logic [reg_addr_w-1:0] wb_rd,
   output lsu_pkg::data_t        wb_data,
   // Stall toward execute
   output logic                  interlock
);
   import lsu_pkg::*;

   data_t load_data;
   data_t fwd_data;
   logic  fwd_hit;

   lsu_dphase_if #(
      .reg_addr_w (reg_addr_w)
   ) dp_if ();

   lsu_addr_phase #(
      .reg_addr_w (reg_addr_w)
   ) i_addr_phase (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req_store    (req_store),
      .req_size     (req_size),
      .req_unsigned (req_unsigned),
      .req_addr     (req_addr),
      .req_wdata    (req_wdata),
      .req_rd       (req_rd),
      .hready       (hready),
      .fwd_hit      (fwd_hit),
      .fwd_data     (fwd_data),
      .interlock    (interlock),
      .haddr        (haddr),
      .htrans       (htrans),
      .hwrite       (hwrite),
      .hsize        (hsize),
      .hwdata       (hwdata),
      .dp           (dp_if.addr_side)
   );

   lsu_load_align i_load_align (
      .hrdata    (hrdata),
      .dp        (dp_if.load_side),
      .load_data (load_data)
   );

   lsu_writeback #(
      .reg_addr_w (reg_addr_w)
   ) i_writeback (
      .hready    (hready),
      .req_valid (req_valid),
      .req_store (req_store),
      .req_rs1   (req_rs1),
      .req_rs2   (req_rs2),
      .load_data (load_data),
      .dp        (dp_if.wb_side),
      .wb_valid  (wb_valid),
      .wb_rd     (wb_rd),
      .wb_data   (wb_data),
      .fwd_hit   (fwd_hit),
      .fwd_data  (fwd_data),
      .interlock (interlock)
   );

endmodule

/* tb/tb_checker.sv */
// LSU checker that models the memory and compares bus and writeback outputs per test
`timescale 1ns/1ps

module tb_checker #(
   parameter int reg_addr_w = 5
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  req_valid,
   input  logic                  req_store,
   input  lsu_pkg::mem_size_e    req_size,
   input  logic                  req_unsigned,
   input  lsu_pkg::data_t        req_addr,
   input  lsu_pkg::data_t        req_wdata,
   input  logic [reg_addr_w-1:0] req_rd,
   input  logic [reg_addr_w-1:0] req_rs1,
   input  logic [reg_addr_w-1:0] req_rs2,
   input  lsu_pkg::data_t        haddr,
   input  logic                  htrans,
   input  logic                  hwrite,
   input  logic [2:0]            hsize,
   input  lsu_pkg::data_t        hwdata,
   input  logic                  hready,
   input  logic                  wb_valid,
   input  logic [reg_addr_w-1:0] wb_rd,
   input  lsu_pkg::data_t        wb_data,
   input  logic                  interlock,
   output int                    done_cnt,
   output int                    err_cnt
);
   import lsu_pkg::*;

   data_t                 ref_mem [0:15];
   logic                  ph_valid;
   logic                  ph_load;
   logic [reg_addr_w-1:0] ph_rd;
   data_t                 ph_data;
   data_t                 ph_addr;
   int                    ph_idx;
   int                    ph_err_base;
   int                    acc_cnt;

   function automatic data_t fill_word(int idx);
      return (idx * 32'h1357_9bdf) ^ 32'h8421_a5c3;
   endfunction

   // Bytes touched by an access of this size and offset
   function automatic data_t lane_mask(mem_size_e size, lane_off_t off);
      if (size == size_byte) return 32'hff << (off * 8);
      if (size == size_half) return 32'hffff << (off[1] * 16);
      return 32'hffff_ffff;
   endfunction

   function automatic data_t place_lanes(data_t v, mem_size_e size, lane_off_t off);
      if (size == size_byte) return {24'h0, v[7:0]} << (off * 8);
      if (size == size_half) return {16'h0, v[15:0]} << (off[1] * 16);
      return v;
   endfunction

   function automatic data_t extract(data_t w, mem_size_e size, lane_off_t off, logic uns);
      data_t s;
      s = w >> (off * 8);
      if (size == size_byte) return uns ? {24'h0, s[7:0]} : {{24{s[7]}}, s[7:0]};
      s = w >> (off[1] * 16);
      if (size == size_half) return uns ? {16'h0, s[15:0]} : {{16{s[15]}}, s[15:0]};
      return w;
   endfunction

   task automatic check_val(string name, data_t exp, data_t got);
      if (exp !== got) begin
         $display("ERROR %s expected %h got %h at %0t", name, exp, got, $time);
         err_cnt++;
      end
   endtask

   initial begin
      done_cnt = 0;
      err_cnt  = 0;
      acc_cnt  = 0;
      ph_valid = 1'b0;
      for (int i = 0; i < 16; i++) ref_mem[i] = fill_word(i);
   end

   // ===================================================================
   // Per-cycle comparison sampled before the edge takes effect
   // ===================================================================

   always @(posedge clk) begin : watch
      logic  pend;
      logic  exp_il;
      logic  fwd;
      data_t src;
      data_t word;
      data_t m;
      if (rst_n) begin
         pend   = ph_valid && ph_load;
         exp_il = req_valid && pend &&
                  (req_rs1 == ph_rd || (req_rs2 == ph_rd && !(req_store && hready)));
         check_val("interlock", data_t'(exp_il), data_t'(interlock));
         check_val("htrans", data_t'(req_valid && !exp_il), data_t'(htrans));
         fwd = req_store && pend && hready && (req_rs2 == ph_rd);

         // Write data keeps its reset value until the first transfer
         if (acc_cnt == 0) check_val("hwdata", 32'h0, hwdata);

         if (ph_valid) begin
            if (!ph_load) check_val("hwdata", ph_data, hwdata);
            if (!hready) begin
               check_val("wb_valid", 32'h0, data_t'(wb_valid));
            end else begin
               check_val("wb_valid", data_t'(ph_load), data_t'(wb_valid));
               if (ph_load) begin
                  check_val("wb_rd", data_t'(ph_rd), data_t'(wb_rd));
                  check_val("wb_data", ph_data, wb_data);
               end
               $display("test %0d: %s at %h %s", ph_idx, ph_load ? "load" : "store",
                        ph_addr, (err_cnt == ph_err_base) ? "passed" : "failed");
               done_cnt++;
               ph_valid = 1'b0;
            end
         end else begin
            check_val("wb_valid", 32'h0, data_t'(wb_valid));
         end

         if (htrans && hready) begin
            ph_err_base = err_cnt;
            check_val("haddr", req_addr, haddr);
            check_val("hwrite", data_t'(req_store), data_t'(hwrite));
            check_val("hsize", data_t'(req_size), data_t'(hsize));
            ph_idx      = acc_cnt;
            ph_addr     = req_addr;
            acc_cnt++;
            if (req_store) begin
               // Forwarded load value replaces the stale store operand
               src  = fwd ? ph_data : req_wdata;
               m    = lane_mask(req_size, req_addr[1:0]);
               word = place_lanes(src, req_size, req_addr[1:0]);
               ref_mem[req_addr[5:2]] = (ref_mem[req_addr[5:2]] & ~m) | (word & m);
               ph_data = word;
               ph_load = 1'b0;
            end else begin
               ph_data = extract(ref_mem[req_addr[5:2]], req_size, req_addr[1:0],
                                 req_unsigned);
               ph_load = 1'b1;
            end
            ph_rd    = req_rd;
            ph_valid = 1'b1;
         end
      end
   end

endmodule

/* tb/tb_lsu.sv */
// LSU testbench: clock, reset, stimulus table, wait-state bus slave and watchdog
`timescale 1ns/1ps

module tb_lsu;
   import lsu_pkg::*;

   localparam int reg_addr_w = 5;
   localparam int n_tests    = 25;

   typedef struct packed {
      logic                  store;
      mem_size_e             size;
      logic                  uns;
      data_t                 addr;
      data_t                 wdata;
      logic [reg_addr_w-1:0] rd;
      logic [reg_addr_w-1:0] rs1;
      logic [reg_addr_w-1:0] rs2;
      logic                  gap;
   } entry_t;

   logic clk;
   logic rst_n;
   logic req_valid;
   logic req_store;
   mem_size_e req_size;
   logic req_unsigned;
   data_t req_addr;
   data_t req_wdata;
   logic [reg_addr_w-1:0] req_rd;
   logic [reg_addr_w-1:0] req_rs1;
   logic [reg_addr_w-1:0] req_rs2;
   data_t hrdata;
   logic hready;
   data_t haddr;
   logic htrans;
   logic hwrite;
   logic [2:0] hsize;
   data_t hwdata;
   logic wb_valid;
   logic [reg_addr_w-1:0] wb_rd;
   data_t wb_data;
   logic interlock;
   int done_cnt;
   int err_cnt;

   entry_t tests [n_tests];
   int     n_added;

   // Slave memory and data-phase state
   data_t     mem [0:15];
   logic      sl_active;
   logic      sl_write;
   data_t     sl_addr;
   logic [2:0] sl_size;
   int        sl_wait;
   logic [31:0] rng;

   lsu_top #(.reg_addr_w(reg_addr_w)) i_dut (
      .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_store(req_store),
      .req_size(req_size), .req_unsigned(req_unsigned), .req_addr(req_addr),
      .req_wdata(req_wdata), .req_rd(req_rd), .req_rs1(req_rs1), .req_rs2(req_rs2),
      .hrdata(hrdata), .hready(hready), .haddr(haddr), .htrans(htrans),
      .hwrite(hwrite), .hsize(hsize), .hwdata(hwdata), .wb_valid(wb_valid),
      .wb_rd(wb_rd), .wb_data(wb_data), .interlock(interlock)
   );

   tb_checker #(.reg_addr_w(reg_addr_w)) i_chk (
      .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_store(req_store),
      .req_size(req_size), .req_unsigned(req_unsigned), .req_addr(req_addr),
      .req_wdata(req_wdata), .req_rd(req_rd), .req_rs1(req_rs1), .req_rs2(req_rs2),
      .haddr(haddr), .htrans(htrans), .hwrite(hwrite), .hsize(hsize), .hwdata(hwdata),
      .hready(hready), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
      .interlock(interlock), .done_cnt(done_cnt), .err_cnt(err_cnt)
   );

   function automatic logic [31:0] xorshift(logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic add_entry(logic store, mem_size_e size, logic uns, data_t addr,
                            data_t wdata, int rd, int rs1, int rs2, logic gap);
      tests[n_added] = '{store, size, uns, addr, wdata, rd[reg_addr_w-1:0],
                         rs1[reg_addr_w-1:0], rs2[reg_addr_w-1:0], gap};
      n_added++;
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ===================================================================
   // Bus slave with 0 to 2 wait states per transfer
   // ===================================================================

   always @(posedge clk) begin
      if (sl_active && hready) begin
         if (sl_write) begin
            case (sl_size)
               3'd0: mem[sl_addr[5:2]][sl_addr[1:0]*8 +: 8] = hwdata[sl_addr[1:0]*8 +: 8];
               3'd1: mem[sl_addr[5:2]][sl_addr[1]*16 +: 16] = hwdata[sl_addr[1]*16 +: 16];
               default: mem[sl_addr[5:2]] = hwdata;
            endcase
         end
         sl_active = 1'b0;
      end
      if (htrans && hready) begin
         sl_active = 1'b1;
         sl_write  = hwrite;
         sl_addr   = haddr;
         sl_size   = hsize;
         rng       = xorshift(rng);
         sl_wait   = rng % 3;
      end
   end

   always @(negedge clk) begin
      if (sl_active && sl_wait > 0) begin
         hready = 1'b0;
         sl_wait--;
      end else begin
         hready = 1'b1;
      end
      hrdata = (sl_active && !sl_write) ? mem[sl_addr[5:2]] : 32'hdead_beef;
   end

   // ===================================================================
   // Stimulus table
   // ===================================================================

   initial begin
      n_added = 0;
      add_entry(1, size_byte, 0, 32'h01, 32'h0000_00a5, 0, 1, 2, 0);
      add_entry(1, size_byte, 0, 32'h06, 32'h0000_005a, 0, 1, 2, 1);
      add_entry(1, size_half, 0, 32'h0a, 32'h0000_8123, 0, 1, 2, 0);
      add_entry(1, size_word, 0, 32'h10, 32'hcafe_f00d, 0, 1, 2, 0);
      add_entry(1, size_half, 0, 32'h1c, 32'h0000_7fee, 0, 1, 2, 1);
      add_entry(0, size_byte, 0, 32'h01, 32'h0, 5, 1, 0, 0);
      add_entry(0, size_byte, 1, 32'h01, 32'h0, 6, 1, 0, 0);
      add_entry(0, size_half, 0, 32'h0a, 32'h0, 7, 1, 0, 0);
      add_entry(0, size_half, 1, 32'h0a, 32'h0, 8, 1, 0, 1);
      add_entry(0, size_word, 0, 32'h10, 32'h0, 9, 1, 0, 0);
      add_entry(0, size_byte, 0, 32'h13, 32'h0, 10, 1, 0, 0);
      add_entry(0, size_byte, 1, 32'h06, 32'h0, 11, 1, 0, 0);
      add_entry(0, size_half, 0, 32'h1c, 32'h0, 12, 1, 0, 0);
      add_entry(0, size_half, 0, 32'h22, 32'h0, 13, 1, 0, 0);
      // Load-use on rs1
      add_entry(0, size_word, 0, 32'h24, 32'h0, 14, 1, 0, 0);
      add_entry(0, size_byte, 0, 32'h24, 32'h0, 19, 14, 0, 1);
      // Load result forwarded into dependent stores
      add_entry(0, size_word, 0, 32'h28, 32'h0, 15, 1, 3, 0);
      add_entry(1, size_byte, 0, 32'h2d, 32'h0000_0011, 0, 1, 15, 0);
      add_entry(0, size_byte, 1, 32'h2d, 32'h0, 16, 1, 0, 0);
      add_entry(1, size_word, 0, 32'h30, 32'h1111_2222, 0, 1, 16, 0);
      add_entry(0, size_word, 0, 32'h30, 32'h0, 17, 1, 0, 1);
      // Load whose rs2 names a pending load
      add_entry(0, size_word, 0, 32'h14, 32'h0, 18, 1, 0, 0);
      add_entry(0, size_half, 0, 32'h16, 32'h0, 20, 0, 18, 0);
      add_entry(1, size_half, 0, 32'h3e, 32'h0000_beef, 0, 1, 2, 1);
      add_entry(0, size_half, 1, 32'h3e, 32'h0, 21, 1, 0, 0);
   end

   initial begin
      rng       = 32'h71a4_d635;
      sl_active = 1'b0;
      sl_wait   = 0;
      for (int i = 0; i < 16; i++) mem[i] = (i * 32'h1357_9bdf) ^ 32'h8421_a5c3;
      rst_n        = 1'b0;
      hready       = 1'b1;
      hrdata       = '0;
      req_valid    = 1'b0;
      req_store    = 1'b0;
      req_size     = size_byte;
      req_unsigned = 1'b0;
      req_addr     = '0;
      req_wdata    = '0;
      req_rd       = '0;
      req_rs1      = '0;
      req_rs2      = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int k = 0; k < n_tests; k++) begin : apply
         logic acc;
         req_valid    = 1'b1;
         req_store    = tests[k].store;
         req_size     = tests[k].size;
         req_unsigned = tests[k].uns;
         req_addr     = tests[k].addr;
         req_wdata    = tests[k].wdata;
         req_rd       = tests[k].rd;
         req_rs1      = tests[k].rs1;
         req_rs2      = tests[k].rs2;
         acc          = 1'b0;
         // Hold until the transfer is accepted
         while (!acc) begin
            @(posedge clk);
            acc = htrans && hready;
            @(negedge clk);
         end
         if (tests[k].gap) begin
            req_valid = 1'b0;
            @(negedge clk);
         end
      end
      req_valid = 1'b0;
      wait (done_cnt == n_tests);
      @(negedge clk);
      $display("tests done %0d of %0d, errors %0d", done_cnt, n_tests, err_cnt);
      if (err_cnt == 0 && done_cnt == n_tests) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // Watchdog sized from the table length
   initial begin
      repeat (5 + n_tests * 8) @(posedge clk);
      $display("Watchdog expired: only %0d of %0d tests finished", done_cnt, n_tests);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

/* src.f */
logic/lsu_pkg.sv
logic/lsu_dphase_if.sv
logic/lsu_addr_phase.sv
logic/lsu_load_align.sv
logic/lsu_writeback.sv
logic/lsu_top.sv
tb/tb_checker.sv
tb/tb_lsu.sv

/* Makefile */
# Verilator build, run and lint for the load/store unit

VERILATOR ?= verilator
FILELIST  ?= src.f
TB_TOP    ?= tb_lsu
RTL_TOP   ?= lsu_top
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP) | tee /dev/stderr | grep -q "=== PASS ==="

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
